//--- build.f
softmc_pkg.sv
instr_receiver.sv
instr_queue.sv
dfi_issuer.sv
softmc_top.sv
softmc_properties.sv
tb_softmc.sv

//--- Bender.yml
package:
  name: softmc

sources:
  - softmc_pkg.sv
  - instr_receiver.sv
  - instr_queue.sv
  - dfi_issuer.sv
  - softmc_top.sv
  - target: test
    files:
      - softmc_properties.sv
      - tb_softmc.sv

//--- tb_softmc.sv
`timescale 1ns/10ps

module tb_softmc;

    localparam int          TIMEOUT_CYCLES = 4000;
    localparam logic [22:0] NOP_CMD        = {4'b1111, 3'b000, 16'h0000};

    logic                 clk = 1'b0;
    logic                 rst;
    logic                 app_en;
    softmc_pkg::instr_t   app_instr;
    logic                 app_ack;
    logic                 iq_full;
    softmc_pkg::dfi_cmd_t dfi_cmd;
    logic                 processing_iseq;

    int     cycle    = 0;
    int     errors   = 0;
    int     pass_cnt = 0;
    int     fail_cnt = 0;
    integer seed     = 32'h31e529d2;

    // Every non-NOP command seen on the DFI side
    logic [22:0] mon_cmd[$];
    int          mon_cyc[$];
    logic        full_seen;
    logic        full_prev;
    int          ack_under_full;

    softmc_top uut (
        .clk             (clk),
        .rst             (rst),
        .app_en          (app_en),
        .app_instr       (app_instr),
        .app_ack         (app_ack),
        .iq_full         (iq_full),
        .dfi_cmd         (dfi_cmd),
        .processing_iseq (processing_iseq)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles before the tests finished", cycle);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Sampled mid-cycle where the outputs are stable
    always @(negedge clk) begin
        if (!rst) begin
            if (dfi_cmd != NOP_CMD) begin
                mon_cmd.push_back(dfi_cmd);
                mon_cyc.push_back(cycle);
            end
            if (iq_full) begin
                full_seen = 1'b1;
            end
            if (app_ack && full_prev) begin
                ack_under_full++;  // Taken while the queue had no room
            end
            full_prev = iq_full;
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
            errors++;
        end
    endtask

    // Reserved bits 30 and 22:16 get random filler
    function automatic softmc_pkg::instr_t make_instr(input logic is_wait, input logic [3:0] cmd,
                                                      input logic [2:0] bank,
                                                      input logic [15:0] opnd);
        logic [31:0] rsvd;
        rsvd = $random(seed);
        return {is_wait, rsvd[7], cmd, bank, rsvd[6:0], opnd};
    endfunction

    function automatic softmc_pkg::instr_t random_cmd();
        logic [31:0] r;
        r = $random(seed);
        return make_instr(1'b0, {1'b0, r[2:0]}, r[5:3], r[31:16]);  // cs_n low
    endfunction

    function automatic logic [22:0] expected_dfi(input softmc_pkg::instr_t instr);
        return {instr[29:26], instr[25:23], instr[15:0]};
    endfunction

    function automatic int wait_len(input softmc_pkg::instr_t instr);
        return (instr[15:0] == 16'd0) ? 1 : int'(instr[15:0]);
    endfunction

    task automatic send_instr(input softmc_pkg::instr_t instr, output int ack_cyc);
        app_en    = 1'b1;
        app_instr = instr;
        do begin
            @(posedge clk);
            #1;
        end while (!app_ack);
        ack_cyc = cycle;
        app_en  = 1'b0;
    endtask

    task automatic wait_idle(output int fall_cyc);
        do begin
            @(posedge clk);
            #1;
        end while (processing_iseq);
        fall_cyc = cycle;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic clear_monitor();
        mon_cmd.delete();
        mon_cyc.delete();
        full_seen      = 1'b0;
        ack_under_full = 0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_cnt++;
            $display("%s passed", name);
        end else begin
            fail_cnt++;
            $display("%s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_reset_state();
        int e0;
        e0 = errors;
        check(app_ack, 0, "app_ack after reset");
        check(iq_full, 0, "iq_full after reset");
        check(processing_iseq, 0, "processing_iseq after reset");
        check(dfi_cmd, NOP_CMD, "dfi_cmd after reset");
        report_test("reset_state", e0);
    endtask

    task automatic test_single_command();
        int                 e0;
        int                 ack;
        int                 fall;
        softmc_pkg::instr_t instr;
        e0 = errors;
        clear_monitor();
        instr = random_cmd();
        send_instr(instr, ack);
        wait_idle(fall);
        check(mon_cmd.size(), 1, "single command count");
        if (mon_cmd.size() == 1) begin
            check(mon_cmd[0], expected_dfi(instr), "decoded command fields");
            check(mon_cyc[0], ack + 1, "command one cycle after ack");
        end
        report_test("single_command", e0);
    endtask

    task automatic run_wait_gap(input int n);
        int                 ack;
        int                 fall;
        softmc_pkg::instr_t cmd_a;
        softmc_pkg::instr_t cmd_b;
        softmc_pkg::instr_t gap;
        clear_monitor();
        cmd_a = random_cmd();
        cmd_b = random_cmd();
        gap   = make_instr(1'b1, 4'hf, 3'd0, 16'(n));
        send_instr(make_instr(1'b1, 4'hf, 3'd0, 16'd40), ack);  // Keeps the issuer busy
        send_instr(cmd_a, ack);
        send_instr(gap, ack);
        send_instr(cmd_b, ack);
        wait_idle(fall);
        check(mon_cmd.size(), 2, $sformatf("command count around wait %0d", n));
        if (mon_cmd.size() == 2) begin
            check(mon_cmd[0], expected_dfi(cmd_a), "command before the wait");
            check(mon_cmd[1], expected_dfi(cmd_b), "command after the wait");
            check(mon_cyc[1] - mon_cyc[0], wait_len(gap) + 1, $sformatf("gap for wait %0d", n));
        end
    endtask

    task automatic test_wait_timing();
        int e0;
        e0 = errors;
        run_wait_gap(0);
        run_wait_gap(1);
        run_wait_gap(6);
        report_test("wait_timing", e0);
    endtask

    task automatic test_back_pressure();
        int                 e0;
        int                 ack;
        int                 fall;
        softmc_pkg::instr_t cmds[20];
        e0 = errors;
        clear_monitor();
        send_instr(make_instr(1'b1, 4'hf, 3'd0, 16'd200), ack);
        for (int i = 0; i < 20; i++) begin
            cmds[i] = random_cmd();
            send_instr(cmds[i], ack);  // Stalls once the queue is full
        end
        wait_idle(fall);
        check(full_seen, 1, "iq_full reached");
        check(ack_under_full, 0, "acks given while full");
        check(mon_cmd.size(), 20, "commands after back-pressure");
        for (int i = 0; i < 20 && i < mon_cmd.size(); i++) begin
            check(mon_cmd[i], expected_dfi(cmds[i]), $sformatf("queued command %0d", i));
        end
        report_test("back_pressure", e0);
    endtask

    task automatic test_random_stream();
        int                 e0;
        int                 fall;
        int                 free_cyc;
        int                 start;
        int                 gaps;
        logic               chain;
        logic               queued;
        softmc_pkg::instr_t stream[61];
        int                 ack_cyc[61];
        logic [22:0]        exp_cmd[$];
        int                 exp_cyc[$];
        logic               exp_gap[$];
        e0 = errors;
        clear_monitor();
        stream[0] = make_instr(1'b1, 4'hf, 3'd0, 16'd60);  // Lets the queue fill up first
        for (int i = 1; i <= 60; i++) begin
            if (($random(seed) & 3) == 0) begin
                stream[i] = make_instr(1'b1, 4'hf, 3'd0, 16'($random(seed) & 7));
            end else begin
                stream[i] = random_cmd();
            end
        end
        for (int i = 0; i <= 60; i++) begin
            send_instr(stream[i], ack_cyc[i]);
        end
        wait_idle(fall);

        // Issuer timeline from the ack cycles
        free_cyc = 0;
        chain    = 1'b0;
        gaps     = 0;
        for (int i = 0; i <= 60; i++) begin
            start  = ack_cyc[i] + 1;
            queued = (free_cyc >= start);  // Entry was waiting when the issuer got ready
            if (queued) begin
                start = free_cyc;
            end
            chain = chain && queued;
            if (stream[i][31]) begin
                free_cyc = start + wait_len(stream[i]);
            end else begin
                exp_cmd.push_back(expected_dfi(stream[i]));
                exp_cyc.push_back(start);
                exp_gap.push_back(chain);
                free_cyc = start + 1;
                chain    = 1'b1;
            end
        end

        check(mon_cmd.size(), exp_cmd.size(), "random stream command count");
        for (int k = 0; k < exp_cmd.size() && k < mon_cmd.size(); k++) begin
            check(mon_cmd[k], exp_cmd[k], $sformatf("stream command %0d", k));
            if (k > 0 && exp_gap[k]) begin
                check(mon_cyc[k] - mon_cyc[k-1], exp_cyc[k] - exp_cyc[k-1],
                      $sformatf("gap before stream command %0d", k));
                gaps++;
            end
        end
        check(fall, free_cyc, "processing_iseq fall after last entry");
        if (gaps == 0) begin
            $display("The random stream had no queued-ahead run, so no gap was compared");
            errors++;
        end
        report_test("random_stream", e0);
    endtask

    initial begin
        rst       = 1'b1;
        app_en    = 1'b0;
        app_instr = '0;
        full_prev = 1'b0;
        clear_monitor();
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        test_reset_state();
        test_single_command();
        test_wait_timing();
        test_back_pressure();
        test_random_stream();

        $display("Summary: %0d passed, %0d failed, %0d errors, %0d assertion failures",
                 pass_cnt, fail_cnt, errors, uut.u_properties.failures);
        if (fail_cnt == 0 && errors == 0 && uut.u_properties.failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- softmc_properties.sv
`timescale 1ns/10ps

module softmc_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 app_ack,
    input logic                 iq_full,
    input logic                 processing_iseq,
    input softmc_pkg::dfi_cmd_t dfi_cmd
);

    int failures = 0;  // Count of failed assertions

    // Ack is a single-cycle pulse
    ack_single_cycle: assert property (@(posedge clk) disable iff (rst)
        app_ack |=> !app_ack)
        else begin
            $error("app_ack stayed high for two cycles");
            failures++;
        end

    // The accepting cycle must have had room in the queue
    ack_needs_room: assert property (@(posedge clk) disable iff (rst)
        $rose(app_ack) |-> !$past(iq_full))
        else begin
            $error("app_ack rose while iq_full was high");
            failures++;
        end

    busy_on_command: assert property (@(posedge clk) disable iff (rst)
        (dfi_cmd != softmc_pkg::DFI_NOP) |-> processing_iseq)
        else begin
            $error("dfi_cmd carries a command while processing_iseq is low");
            failures++;
        end

endmodule

bind softmc_top softmc_properties u_properties (.*);

//--- softmc_top.sv
`timescale 1ns/10ps

module softmc_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 app_en,
    input  softmc_pkg::instr_t   app_instr,
    output logic                 app_ack,
    output logic                 iq_full,
    output softmc_pkg::dfi_cmd_t dfi_cmd,
    output logic                 processing_iseq
);

    logic                  push;
    softmc_pkg::iq_entry_t push_entry;
    logic                  pop;
    softmc_pkg::iq_entry_t head;
    logic                  empty;

    // Host side
    instr_receiver u_receiver (
        .clk        (clk),
        .rst        (rst),
        .app_en     (app_en),
        .app_instr  (app_instr),
        .iq_full    (iq_full),
        .app_ack    (app_ack),
        .push       (push),
        .push_entry (push_entry)
    );

    instr_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       (iq_full)    // Also seen by the host
    );

    // DFI side
    dfi_issuer u_issuer (
        .clk             (clk),
        .rst             (rst),
        .head            (head),
        .empty           (empty),
        .pop             (pop),
        .dfi_cmd         (dfi_cmd),
        .processing_iseq (processing_iseq)
    );

endmodule

//--- dfi_issuer.sv
`timescale 1ns/10ps

module dfi_issuer (
    input  logic                  clk,
    input  logic                  rst,
    input  softmc_pkg::iq_entry_t head,
    input  logic                  empty,
    output logic                  pop,
    output softmc_pkg::dfi_cmd_t  dfi_cmd,
    output logic                  processing_iseq
);

    softmc_pkg::issuer_state_t state;
    softmc_pkg::wait_cnt_t     wait_cnt;
    softmc_pkg::dfi_cmd_t      head_cmd;
    logic                      cmd_active;  // A real command is on dfi_cmd
    logic                      ready;

    // Ready in idle, or in the last NOP cycle of a wait
    // A count of 0 behaves as 1
    assign ready = (state == softmc_pkg::ST_IDLE) ||
                   (wait_cnt <= softmc_pkg::wait_cnt_t'(1));

    assign pop = ready && !empty;

    assign processing_iseq = cmd_active || (state == softmc_pkg::ST_WAIT) || !empty;

    // Command fields of the head entry
    always_comb begin
        head_cmd.cs_n    = head.cs_n;
        head_cmd.ras_n   = head.ras_n;
        head_cmd.cas_n   = head.cas_n;
        head_cmd.we_n    = head.we_n;
        head_cmd.bank    = head.bank;
        head_cmd.address = head.operand;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= softmc_pkg::ST_IDLE;
            wait_cnt   <= '0;
            cmd_active <= 1'b0;
            dfi_cmd    <= softmc_pkg::DFI_NOP;
        end else if (pop) begin
            if (head.is_wait) begin
                // NOP run starts in the next cycle
                state      <= softmc_pkg::ST_WAIT;
                wait_cnt   <= head.operand;
                cmd_active <= 1'b0;
                dfi_cmd    <= softmc_pkg::DFI_NOP;
            end else begin
                state      <= softmc_pkg::ST_IDLE;
                cmd_active <= 1'b1;
                dfi_cmd    <= head_cmd;  // Held for exactly one cycle
            end
        end else begin
            cmd_active <= 1'b0;
            dfi_cmd    <= softmc_pkg::DFI_NOP;
            if (ready) begin
                state <= softmc_pkg::ST_IDLE;  // Wait done and nothing queued
            end else begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

endmodule

//--- instr_queue.sv
`timescale 1ns/10ps

module instr_queue (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  softmc_pkg::iq_entry_t push_entry,
    input  logic                  pop,
    output softmc_pkg::iq_entry_t head,
    output logic                  empty,
    output logic                  full
);

    softmc_pkg::iq_entry_t mem [softmc_pkg::IQ_DEPTH];

    logic [softmc_pkg::IQ_PTR_W-1:0] wr_ptr;
    logic [softmc_pkg::IQ_PTR_W-1:0] rd_ptr;
    logic [softmc_pkg::IQ_PTR_W:0]   count;  // One extra bit to tell full from empty

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle, or push and pop together
            endcase
        end
    end

    // First word falls through
    assign head  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == (softmc_pkg::IQ_PTR_W + 1)'(softmc_pkg::IQ_DEPTH));

endmodule

//--- instr_receiver.sv
`timescale 1ns/10ps

module instr_receiver (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  app_en,
    input  softmc_pkg::instr_t    app_instr,
    input  logic                  iq_full,
    output logic                  app_ack,
    output logic                  push,
    output softmc_pkg::iq_entry_t push_entry
);

    logic accept;

    // The host holds app_en until it sees the ack, so a high ack
    // blocks a second take of the same word
    assign accept = app_en && !app_ack && !iq_full;
    assign push   = accept;  // Write lands on the ack edge

    always_ff @(posedge clk) begin
        if (rst) begin
            app_ack <= 1'b0;
        end else begin
            app_ack <= accept;  // One-cycle pulse
        end
    end

    // Field split, reserved bits 30 and 22:16 dropped
    always_comb begin
        push_entry.is_wait = app_instr[softmc_pkg::KIND_BIT];
        {push_entry.cs_n, push_entry.ras_n, push_entry.cas_n, push_entry.we_n} =
            app_instr[softmc_pkg::CMD_HI:softmc_pkg::CMD_LO];
        push_entry.bank    = app_instr[softmc_pkg::BANK_HI:softmc_pkg::BANK_LO];
        push_entry.operand = app_instr[softmc_pkg::OPND_HI:softmc_pkg::OPND_LO];
    end

endmodule

//--- softmc_pkg.sv
package softmc_pkg;

    // Host and DRAM widths
    localparam int INSTR_W  = 32;
    localparam int ROW_W    = 16;
    localparam int BANK_W   = 3;
    localparam int WAIT_W   = 16;

    // Instruction queue sizing
    localparam int IQ_DEPTH = 16;
    localparam int IQ_PTR_W = 4;   // log2(IQ_DEPTH)

    // Instruction word layout
    localparam int KIND_BIT = 31;  // 1 marks a wait
    localparam int CMD_HI   = 29;  // cs_n ras_n cas_n we_n
    localparam int CMD_LO   = 26;
    localparam int BANK_HI  = 25;
    localparam int BANK_LO  = 23;
    localparam int OPND_HI  = 15;  // Address or wait count
    localparam int OPND_LO  = 0;

    typedef logic [INSTR_W-1:0] instr_t;
    typedef logic [ROW_W-1:0]   row_t;
    typedef logic [BANK_W-1:0]  bank_t;
    typedef logic [WAIT_W-1:0]  wait_cnt_t;

    // Decoded instruction as held in the queue
    typedef struct packed {
        logic  is_wait;
        logic  cs_n;
        logic  ras_n;
        logic  cas_n;
        logic  we_n;
        bank_t bank;
        row_t  operand;  // Address for a command, count for a wait
    } iq_entry_t;

    // One DFI phase of control and address
    typedef struct packed {
        logic  cs_n;
        logic  ras_n;
        logic  cas_n;
        logic  we_n;
        bank_t bank;
        row_t  address;
    } dfi_cmd_t;

    localparam dfi_cmd_t DFI_NOP = '{cs_n: 1'b1, ras_n: 1'b1, cas_n: 1'b1, we_n: 1'b1,
                                     bank: '0, address: '0};

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_WAIT = 1'b1
    } issuer_state_t;

endpackage
